//--- include/csr_macros.svh
/*
 * Constants of the machine-mode CSR unit: data widths, compressed CSR
 * address indices, system function codes, cause codes and fixed read values.
 * Included by the package and by every module that decodes CSRs.
 */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`define XLEN            32
`define CSR_ADDR_W      5
`define CAUSE_W         5

// compressed CSR address indices, payload bits 4:0
`define CSR_STATUS      5'h00
`define CSR_ISA         5'h01
`define CSR_IE          5'h04
`define CSR_TVEC        5'h05
`define CSR_SCRATCH     5'h08
`define CSR_EPC         5'h09
`define CSR_CAUSE       5'h0A
`define CSR_TVAL        5'h0B
`define CSR_IP          5'h0C
`define CSR_CYCLE       5'h10
`define CSR_CYCLEH      5'h11
`define CSR_INSTRET     5'h12
`define CSR_INSTRETH    5'h13
`define CSR_HARTID      5'h14

// system function in payload bits 11:9
`define CSR_FUN_ECALL   3'b000
`define CSR_FUN_EBREAK  3'b001
`define CSR_FUN_RET     3'b010

`define EXC_IACCESS_VAL 5'd1
`define EXC_ILLEGAL_VAL 5'd2
`define EXC_EBREAK_VAL  5'd3
`define EXC_LMISAL_VAL  5'd4
`define EXC_LACCESS_VAL 5'd5
`define EXC_SMISAL_VAL  5'd6
`define EXC_SACCESS_VAL 5'd7
`define EXC_ECALL_VAL   5'd11

`define INT_MSI_VAL     5'd3
`define INT_MTI_VAL     5'd7
`define INT_MEI_VAL     5'd11

`define ISA_VALUE         32'h40001104    // rv32 i/m/c
`define MSTATUS_MPP_FIXED 2'b11           // only machine mode exists

`endif

//--- hdl/csr_pkg.sv
/*
 * Types shared by the CSR unit: the fetch misconduct indicator, the CSR
 * operation, the decoded-instruction struct and the exception flag vector.
 */
`include "csr_macros.svh"

package csr_pkg;

    // misconduct reported by the fetch stage
    typedef enum logic [1:0] {
        IMISCON_NONE = 2'b00,
        IMISCON_ILLE = 2'b01,   // illegal encoding
        IMISCON_FERR = 2'b10,   // fetch bus error
        IMISCON_PMAV = 2'b11    // pma violation
    } imiscon_t;

    typedef enum logic [1:0] {
        CSR_OP_NONE  = 2'b00,
        CSR_OP_WRITE = 2'b01,
        CSR_OP_SET   = 2'b10,
        CSR_OP_CLEAR = 2'b11
    } csr_op_t;

    // decoded CSR-unit instruction, already gated by flush and stall
    typedef struct packed {
        csr_op_t                 op;
        logic [`CSR_ADDR_W-1:0]  addr;
        logic                    machine;   // level bits are 11
        logic [1:0]              uclass;    // user-address class
        logic                    mret;
        logic                    ecall;
        logic                    ebreak;
        logic                    commit;
    } csr_dec_t;

    typedef struct packed {
        logic iaccess;
        logic illegal;
        logic ecall;
        logic ebreak;
        logic misaligned;
        logic lsaccess;
    } exc_vec_t;

endpackage

//--- hdl/csr_decode.sv
/*
 * Decoder of the CSR-unit instruction. Splits the payload into address,
 * level and user-address class, maps the function code to a CSR operation and
 * spots mret, ecall and ebreak. Flush and stall gating happens only here.
 */
`include "csr_macros.svh"

module csr_decode import csr_pkg::*; (
    input  logic        valid_i,
    input  logic        unit_csr_i,
    input  logic        flush_i,
    input  logic        stall_i,
    input  logic [3:0]  function_i,
    input  logic [11:0] payload_i,
    output csr_dec_t    dec_o
);
    logic    csr_ins;    // instruction for this unit
    logic    sys_fun;    // ecall, ebreak or ret
    csr_op_t op;

    assign csr_ins = valid_i & unit_csr_i;
    assign sys_fun = csr_ins & (function_i == 4'b0000);

    always_comb begin
        case (function_i)
            4'b0001: op = CSR_OP_WRITE;
            4'b0010: op = CSR_OP_SET;
            4'b0011: op = CSR_OP_CLEAR;
            default: op = CSR_OP_NONE;
        endcase
    end

    // a flushed instruction never touches a register
    assign dec_o.op      = (csr_ins & ~flush_i) ? op : CSR_OP_NONE;
    assign dec_o.addr    = payload_i[4:0];
    assign dec_o.machine = payload_i[6:5] == 2'b11;
    assign dec_o.uclass  = payload_i[8:7];

    assign dec_o.mret    = sys_fun & ~flush_i & (payload_i[11:9] == `CSR_FUN_RET)
                         & (payload_i[6:5] == 2'b11) & (payload_i[8:7] == 2'b00);
    assign dec_o.ecall   = sys_fun & (payload_i[11:9] == `CSR_FUN_ECALL);
    assign dec_o.ebreak  = sys_fun & (payload_i[11:9] == `CSR_FUN_EBREAK);

    // held instruction retires once, when the stall lifts
    assign dec_o.commit  = valid_i & ~stall_i & ~flush_i;

endmodule

//--- hdl/exc_detect.sv
/*
 * Synchronous exception detection for the instruction in the memory stage.
 * Collects the fault sources into one flag vector and picks the cause code
 * of the highest-priority exception.
 */
`include "csr_macros.svh"

module exc_detect import csr_pkg::*; (
    input  logic                unit_lsu_i,
    input  logic                store_i,
    input  logic [1:0]          width_i,    // 00 byte, 01 half, 10 word
    input  logic                hresp_i,
    input  imiscon_t            imiscon_i,
    input  logic                valid_i,
    input  logic                rstpp_i,
    input  csr_dec_t            dec_i,
    input  logic [31:0]         addr_i,
    output logic                exception_o,
    output logic                execute_o,
    output logic [`CAUSE_W-1:0] exc_code_o
);
    exc_vec_t exc;
    logic     lsu_op, pma_violation, misaligned;

    assign lsu_op        = valid_i & unit_lsu_i;
    assign pma_violation = imiscon_i == IMISCON_PMAV;
    assign misaligned    = ((width_i == 2'b10) & (|addr_i[1:0]))
                         | ((width_i == 2'b01) & addr_i[0]);

    assign exc.iaccess    = (imiscon_i == IMISCON_FERR) | (pma_violation & ~unit_lsu_i);
    assign exc.illegal    = imiscon_i == IMISCON_ILLE;
    assign exc.ecall      = dec_i.ecall;
    assign exc.ebreak     = dec_i.ebreak;
    assign exc.misaligned = lsu_op & misaligned;
    assign exc.lsaccess   = lsu_op & (hresp_i | pma_violation);

    assign exception_o = |exc;
    // fetch faults count as executed even without a valid instruction
    assign execute_o   = (valid_i | exc.iaccess | exc.illegal) & ~rstpp_i;

    assign exc_code_o = exc.iaccess    ? `EXC_IACCESS_VAL :
                        exc.illegal    ? `EXC_ILLEGAL_VAL :
                        exc.ecall      ? `EXC_ECALL_VAL   :
                        exc.ebreak     ? `EXC_EBREAK_VAL  :
                        exc.misaligned ? (store_i ? `EXC_SMISAL_VAL : `EXC_LMISAL_VAL) :
                                         (store_i ? `EXC_SACCESS_VAL : `EXC_LACCESS_VAL);

endmodule

//--- hdl/irq_ctrl.sv
/*
 * Interrupt evaluation. Flags a pending interrupt from mie, mip and the
 * global enable, selects the interrupt cause code and forms the exception
 * and interrupt trap-handler addresses from mtvec.
 */
`include "csr_macros.svh"

module irq_ctrl import csr_pkg::*; (
    input  logic [11:0]         mie_i,
    input  logic [11:0]         mip_i,
    input  logic                gie_i,      // mstatus.MIE
    input  logic [`XLEN-1:0]    mtvec_i,
    output logic                int_pending_o,
    output logic [`CAUSE_W-1:0] int_code_o,
    output logic [`XLEN-1:0]    exc_trap_o,
    output logic [`XLEN-1:0]    int_trap_o
);
    logic [11:0]      active;
    logic [`XLEN-1:0] vector_offset;

    assign active        = mie_i & mip_i;
    assign int_pending_o = (|active) & gie_i;

    // external first, then software, timer last
    assign int_code_o = active[11] ? `INT_MEI_VAL :
                        active[3]  ? `INT_MSI_VAL :
                                     `INT_MTI_VAL;

    assign exc_trap_o    = {mtvec_i[31:2], 2'b00};
    assign vector_offset = {{(`XLEN-`CAUSE_W-2){1'b0}}, int_code_o, 2'b00};

    // vectored mode when mtvec bit 0 is set
    assign int_trap_o = mtvec_i[0] ? exc_trap_o + vector_offset : exc_trap_o;

endmodule

//--- hdl/csr_counters.sv
/*
 * The 64-bit mcycle and minstret counters. mcycle counts every clock,
 * minstret counts committed instructions. A CSR write to one half replaces
 * that half while the other half follows the count.
 */
`include "csr_macros.svh"

module csr_counters import csr_pkg::*; (
    input  logic             clk_i,
    input  logic             reset_i,
    input  csr_dec_t         dec_i,
    input  logic [`XLEN-1:0] wdata_i,
    output logic [63:0]      cycle_o,
    output logic [63:0]      instret_o
);
    logic [63:0] cycle_q, instret_q;
    logic [63:0] cycle_nxt, instret_nxt;
    logic        cnt_wr;

    // counters live in user-address class 10
    assign cnt_wr = (dec_i.op != CSR_OP_NONE) & dec_i.machine & (dec_i.uclass == 2'b10);

    always_comb begin
        cycle_nxt   = cycle_q + 64'd1;
        instret_nxt = dec_i.commit ? instret_q + 64'd1 : instret_q;
        if (cnt_wr && dec_i.addr == `CSR_CYCLE)    cycle_nxt[31:0]    = wdata_i;
        if (cnt_wr && dec_i.addr == `CSR_CYCLEH)   cycle_nxt[63:32]   = wdata_i;
        if (cnt_wr && dec_i.addr == `CSR_INSTRET)  instret_nxt[31:0]  = wdata_i;
        if (cnt_wr && dec_i.addr == `CSR_INSTRETH) instret_nxt[63:32] = wdata_i;
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q   <= cycle_nxt;
            instret_q <= instret_nxt;
        end
    end

    assign cycle_o   = cycle_q;
    assign instret_o = instret_q;

endmodule

//--- hdl/csr_regfile.sv
/*
 * Machine trap and status registers. Provides the CSR read value and the
 * read-modify-write value, samples the interrupt lines into mip, and
 * applies trap entry, mret and CSR writes in that order of priority.
 */
`include "csr_macros.svh"

module csr_regfile import csr_pkg::*; (
    input  logic                clk_i,
    input  logic                reset_i,
    input  csr_dec_t            dec_i,
    input  logic [`XLEN-1:0]    val_i,
    input  logic [`XLEN-1:0]    epc_i,
    input  logic                meip_i,
    input  logic                mtip_i,
    input  logic                msip_i,
    input  logic                trap_i,         // exception or interrupt taken
    input  logic                interrupted_i,
    input  logic                exc_active_i,   // exception taken, no interrupt
    input  logic [`CAUSE_W-1:0] exc_code_i,
    input  logic [`CAUSE_W-1:0] int_code_i,
    input  logic [63:0]         cycle_i,
    input  logic [63:0]         instret_i,
    output logic [`XLEN-1:0]    rdata_o,
    output logic [`XLEN-1:0]    wdata_o,
    output logic [`XLEN-1:0]    mepc_o,
    output logic [`XLEN-1:0]    mtvec_o,
    output logic [11:0]         mie_o,
    output logic [11:0]         mip_o,
    output logic                gie_o
);
    logic [`XLEN-1:0] mtvec_q, mepc_q, mcause_q, mtval_q, mscratch_q;
    logic [11:0]      mie_q, mip_q;
    logic             st_mie_q, st_mpie_q;      // the only live mstatus bits
    logic [`XLEN-1:0] rdata, wdata;
    logic             wr_en, misaligned;

    assign wr_en      = (dec_i.op != CSR_OP_NONE) & dec_i.machine & (dec_i.uclass == 2'b00);
    assign misaligned = (exc_code_i == `EXC_LMISAL_VAL) | (exc_code_i == `EXC_SMISAL_VAL);

    always_comb begin
        case (dec_i.addr)
            `CSR_STATUS:   rdata = {19'b0, `MSTATUS_MPP_FIXED, 3'b0, st_mpie_q,
                                    3'b0, st_mie_q, 3'b0};
            `CSR_ISA:      rdata = `ISA_VALUE;
            `CSR_IE:       rdata = {20'b0, mie_q};
            `CSR_TVEC:     rdata = mtvec_q;
            `CSR_SCRATCH:  rdata = mscratch_q;
            `CSR_EPC:      rdata = mepc_q;
            `CSR_CAUSE:    rdata = mcause_q;
            `CSR_TVAL:     rdata = mtval_q;
            `CSR_IP:       rdata = {20'b0, mip_q};
            `CSR_CYCLE:    rdata = cycle_i[31:0];
            `CSR_CYCLEH:   rdata = cycle_i[63:32];
            `CSR_INSTRET:  rdata = instret_i[31:0];
            `CSR_INSTRETH: rdata = instret_i[63:32];
            default:       rdata = '0;      // mhartid and unknown addresses
        endcase
    end

    always_comb begin
        case (dec_i.op)
            CSR_OP_WRITE: wdata = val_i;
            CSR_OP_SET:   wdata = val_i | rdata;
            CSR_OP_CLEAR: wdata = ~val_i & rdata;
            default:      wdata = rdata;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            {st_mie_q, st_mpie_q} <= 2'b00;
            {mie_q, mip_q}        <= '0;
            mtvec_q    <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
            mtval_q    <= '0;
            mscratch_q <= '0;
        end else begin
            mip_q <= {meip_i, 3'b0, mtip_i, 3'b0, msip_i, 3'b0};   // sampled every cycle
            if (trap_i) begin
                st_mpie_q <= st_mie_q;
                st_mie_q  <= 1'b0;
                mepc_q    <= epc_i;
                mcause_q  <= {interrupted_i, 26'b0, interrupted_i ? int_code_i : exc_code_i};
                if (exc_active_i) begin
                    mtval_q <= misaligned ? val_i : '0;    // faulting address
                end
            end else if (dec_i.mret) begin
                st_mie_q  <= st_mpie_q;
                st_mpie_q <= 1'b1;
            end else if (wr_en) begin
                case (dec_i.addr)
                    `CSR_STATUS: begin
                        st_mie_q  <= wdata[3];
                        st_mpie_q <= wdata[7];
                    end
                    `CSR_IE:      mie_q      <= {wdata[11], 3'b0, wdata[7], 3'b0, wdata[3], 3'b0};
                    `CSR_TVEC:    mtvec_q    <= {wdata[31:2], 1'b0, wdata[0]};
                    `CSR_SCRATCH: mscratch_q <= wdata;
                    `CSR_EPC:     mepc_q     <= wdata;
                    `CSR_CAUSE:   mcause_q   <= wdata;
                    `CSR_TVAL:    mtval_q    <= wdata;
                    default: ;
                endcase
            end
        end
    end

    assign rdata_o = rdata;
    assign wdata_o = wdata;
    assign mepc_o  = mepc_q;
    assign mtvec_o = mtvec_q;
    assign mie_o   = mie_q;
    assign mip_o   = mip_q;
    assign gie_o   = st_mie_q;

endmodule

//--- hdl/csr_unit.sv
/*
 * Machine-mode CSR unit of the memory-access stage. Connects the decoder,
 * exception and interrupt logic, counters and trap/status registers.
 */
`include "csr_macros.svh"

module csr_unit import csr_pkg::*; (
    input  logic             clk_i,
    input  logic             reset_i,
    input  logic             valid_i,
    input  logic             unit_csr_i,
    input  logic             unit_lsu_i,
    input  logic             store_i,
    input  logic [1:0]       width_i,
    input  logic [3:0]       function_i,
    input  logic [11:0]      payload_i,
    input  logic [`XLEN-1:0] val_i,         // result from execute, also lsu address
    input  logic [`XLEN-1:0] epc_i,         // trap return address
    input  logic             stall_i,
    input  logic             flush_i,
    input  logic             rstpp_i,
    input  logic             hresp_i,
    input  imiscon_t         imiscon_i,
    input  logic             interrupted_i,
    input  logic             meip_i,
    input  logic             mtip_i,
    input  logic             msip_i,
    output logic [`XLEN-1:0] csr_rdata_o,
    output logic [`XLEN-1:0] exc_trap_o,
    output logic [`XLEN-1:0] int_trap_o,
    output logic [`XLEN-1:0] mepc_o,
    output logic             mret_o,
    output logic             exception_o,
    output logic             int_pending_o
);
    csr_dec_t            dec;
    logic                exception, execute, exc_active, trap, gie;
    logic [`CAUSE_W-1:0] exc_code, int_code;
    logic [`XLEN-1:0]    wdata, mtvec;
    logic [11:0]         mie, mip;
    logic [63:0]         cycle, instret;

    // an interrupt approval wins over a simultaneous exception
    assign exc_active  = exception & execute & ~interrupted_i;
    assign trap        = interrupted_i | (exception & execute);
    assign mret_o      = dec.mret;
    assign exception_o = exception;

    csr_decode csr_decode_inst (
        .valid_i(valid_i), .unit_csr_i(unit_csr_i), .flush_i(flush_i), .stall_i(stall_i),
        .function_i(function_i), .payload_i(payload_i), .dec_o(dec));

    exc_detect exc_detect_inst (
        .unit_lsu_i(unit_lsu_i), .store_i(store_i), .width_i(width_i), .hresp_i(hresp_i),
        .imiscon_i(imiscon_i), .valid_i(valid_i), .rstpp_i(rstpp_i), .dec_i(dec),
        .addr_i(val_i), .exception_o(exception), .execute_o(execute),
        .exc_code_o(exc_code));

    irq_ctrl irq_ctrl_inst (
        .mie_i(mie), .mip_i(mip), .gie_i(gie), .mtvec_i(mtvec),
        .int_pending_o(int_pending_o), .int_code_o(int_code),
        .exc_trap_o(exc_trap_o), .int_trap_o(int_trap_o));

    csr_counters csr_counters_inst (
        .clk_i(clk_i), .reset_i(reset_i), .dec_i(dec), .wdata_i(wdata),
        .cycle_o(cycle), .instret_o(instret));

    csr_regfile csr_regfile_inst (
        .clk_i(clk_i), .reset_i(reset_i), .dec_i(dec), .val_i(val_i), .epc_i(epc_i),
        .meip_i(meip_i), .mtip_i(mtip_i), .msip_i(msip_i), .trap_i(trap),
        .interrupted_i(interrupted_i), .exc_active_i(exc_active), .exc_code_i(exc_code),
        .int_code_i(int_code), .cycle_i(cycle), .instret_i(instret),
        .rdata_o(csr_rdata_o), .wdata_o(wdata), .mepc_o(mepc_o), .mtvec_o(mtvec),
        .mie_o(mie), .mip_o(mip), .gie_o(gie));

endmodule

//--- sim/csr_unit_tb.sv
/*
 * Testbench of the CSR unit. Replays sim/csr_trace.txt one line per clock,
 * driving the pipeline inputs shortly after each rising edge and checking
 * the outputs that the line's mask selects. Run from the project root.
 */
module csr_unit_tb import csr_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_LINES    = 31;
    localparam int N_WORDS    = 8;              // words per trace line
    localparam int MAX_CYCLES = N_LINES + 20;

    logic        clk;
    logic        reset;
    logic        valid, unit_csr, unit_lsu, store;
    logic [1:0]  width;
    logic [3:0]  func;
    logic [11:0] payload;
    logic [31:0] val, epc;
    logic        stall, flush, rstpp, hresp;
    imiscon_t    imiscon;
    logic        interrupted, meip, mtip, msip;
    logic [31:0] csr_rdata, exc_trap, int_trap, mepc;
    logic        mret, exception, int_pending;

    logic [31:0] trace [N_LINES*N_WORDS];
    int          cycles = 0;

    csr_unit csr_unit_inst (
        .clk_i(clk), .reset_i(reset), .valid_i(valid), .unit_csr_i(unit_csr),
        .unit_lsu_i(unit_lsu), .store_i(store), .width_i(width), .function_i(func),
        .payload_i(payload), .val_i(val), .epc_i(epc), .stall_i(stall),
        .flush_i(flush), .rstpp_i(rstpp), .hresp_i(hresp), .imiscon_i(imiscon),
        .interrupted_i(interrupted), .meip_i(meip), .mtip_i(mtip), .msip_i(msip),
        .csr_rdata_o(csr_rdata), .exc_trap_o(exc_trap), .int_trap_o(int_trap),
        .mepc_o(mepc), .mret_o(mret), .exception_o(exception),
        .int_pending_o(int_pending));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // run limit in clock cycles
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Something failed");
            $fatal(1, "timeout: trace did not finish");
        end
    end

    // unpack one trace line onto the DUT inputs
    task automatic drive_line(input int n);
        logic [31:0] ctrl;
        logic [31:0] io;
        ctrl = trace[n*N_WORDS];
        io   = trace[n*N_WORDS+3];
        valid       = ctrl[31];
        unit_csr    = ctrl[30];
        unit_lsu    = ctrl[29];
        store       = ctrl[28];
        width       = ctrl[25:24];
        func        = ctrl[23:20];
        stall       = ctrl[19];
        flush       = ctrl[18];
        rstpp       = ctrl[17];
        hresp       = ctrl[16];
        imiscon     = imiscon_t'(ctrl[13:12]);
        payload     = ctrl[11:0];
        val         = trace[n*N_WORDS+1];
        epc         = trace[n*N_WORDS+2];
        interrupted = io[11];
        meip        = io[10];
        mtip        = io[9];
        msip        = io[8];
    endtask

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Error: %s expected %h got %h", name, expected, actual);
            $display("Something failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // compare the outputs enabled by the line's mask
    task automatic check_line(input int n);
        int          base;
        logic [31:0] io;
        base = n * N_WORDS;
        io   = trace[base+3];
        if (io[23]) check_word("csr_rdata_o", trace[base+4], csr_rdata);
        if (io[22]) check_word("exc_trap_o", trace[base+5], exc_trap);
        if (io[21]) check_word("int_trap_o", trace[base+6], int_trap);
        if (io[20]) check_word("mepc_o", trace[base+7], mepc);
        if (io[18]) check_word("mret_o", {31'b0, io[6]}, {31'b0, mret});
        if (io[17]) check_word("exception_o", {31'b0, io[5]}, {31'b0, exception});
        if (io[16]) check_word("int_pending_o", {31'b0, io[4]}, {31'b0, int_pending});
    endtask

    initial begin
        reset       = 1'b1;
        valid       = 1'b0;
        unit_csr    = 1'b0;
        unit_lsu    = 1'b0;
        store       = 1'b0;
        width       = 2'b00;
        func        = 4'h0;
        payload     = 12'h000;
        val         = 32'h0;
        epc         = 32'h0;
        stall       = 1'b0;
        flush       = 1'b0;
        rstpp       = 1'b0;
        hresp       = 1'b0;
        imiscon     = IMISCON_NONE;
        interrupted = 1'b0;
        meip        = 1'b0;
        mtip        = 1'b0;
        msip        = 1'b0;
        $readmemh("sim/csr_trace.txt", trace);

        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < N_LINES; n++) begin
            drive_line(n);
            #7;             // settled, next edge 2 ns away
            check_line(n);
            @(posedge clk);
            #1;
        end
        $display("Everything OK");
        $finish;
    end

endmodule

//--- sim/csr_trace.txt
// ctrl {valid,csr,lsu,store | width | func | stall,flush,rstpp,hresp | imiscon | payload}, val, epc,
// io {mask 23:20 rdata,etrap,itrap,mepc; 18:16 mret,exc,pend; 11:8 int,meip,mtip,msip; 6:4 flags}, rdata, etrap, itrap, mepc
C0100068 12345678 00000000 00870000 00000000 00000000 00000000 00000000
C0200068 0000F00F 00000000 00870000 12345678 00000000 00000000 00000000
C0300068 00FF0000 00000000 00870000 1234F67F 00000000 00000000 00000000
C0140068 DEADBEEF 00000000 00870000 1200F67F 00000000 00000000 00000000
C0400068 00000000 00000000 00870000 1200F67F 00000000 00000000 00000000
C0100060 FFFFFFFF 00000000 00870000 00001800 00000000 00000000 00000000
C0400060 00000000 00000000 00870000 00001888 00000000 00000000 00000000
C0400061 00000000 00000000 00870000 40001104 00000000 00000000 00000000
C0400074 00000000 00000000 00870000 00000000 00000000 00000000 00000000
C0100065 00000103 00000000 00870000 00000000 00000000 00000000 00000000
C0400065 00000000 00000000 00C70000 00000101 00000100 00000000 00000000
C0100064 00000880 00000000 00870000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00070200 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00270610 00000000 00000000 0000011C 00000000
00000000 00000000 00000400 00270E10 00000000 00000000 0000012C 00000000
C040006A 00000000 00000000 00970000 8000000B 00000000 00000000 00000400
C0400060 00000000 00000000 00870000 00001880 00000000 00000000 00000000
C0000460 00000000 00000000 00870040 00001880 00000000 00000000 00000000
C0400060 00000000 00000000 00870000 00001888 00000000 00000000 00000000
C0001000 00000000 00000200 00870020 00001888 00000000 00000000 00000000
C040006A 00000000 00000000 00970000 00000002 00000000 00000000 00000200
B2000000 00001002 00000300 00070020 00000000 00000000 00000000 00000000
C040006A 00000000 00000000 00970000 00000006 00000000 00000000 00000300
C040006B 00000000 00000000 00870000 00001002 00000000 00000000 00000000
C0400170 00000000 00000000 00870000 00000018 00000000 00000000 00000000
C0400170 00000000 00000000 00870000 00000019 00000000 00000000 00000000
C0480172 00000000 00000000 00870000 00000016 00000000 00000000 00000000
C0480172 00000000 00000000 00870000 00000016 00000000 00000000 00000000
C0100171 000000AB 00000000 00870000 00000000 00000000 00000000 00000000
C0400171 00000000 00000000 00870000 000000AB 00000000 00000000 00000000
C0400170 00000000 00000000 00870000 0000001E 00000000 00000000 00000000

//--- flist.f
+incdir+include
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/exc_detect.sv
hdl/irq_ctrl.sv
hdl/csr_counters.sv
hdl/csr_regfile.sv
hdl/csr_unit.sv
sim/csr_unit_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP       = csr_unit_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
